/* design/board_consts.svh */
`ifndef BOARD_CONSTS_SVH
`define BOARD_CONSTS_SVH

// debounce length in clk_cpu cycles
// a raw input must hold its new level this long
// short value for simulation, board build wants thousands
`define JITTER_MAX 4

// cycles sys_rst stays high after rst_i falls
`define RST_STRETCH 16

// clk_cpu cycles per uart bit
`define UART_DIV 16

// clk_cpu cycles per half period of the display serial clock
`define DISP_DIV 2

`endif

/* design/board_pkg.sv */
package board_pkg;

	// data byte on both uart links
	typedef logic [7:0] byte_t;

	// board inputs
	typedef logic [15:0] switch_t;
	typedef logic [3:0] btn_t;

	// display words
	typedef logic [31:0] disp_word_t;
	typedef logic [15:0] led_word_t;

	// conditioned user inputs, switches in the upper bits
	typedef struct packed {
		switch_t sw;
		btn_t btn;
	} ui_in_t;

	// one display frame, segment data then led word
	typedef struct packed {
		disp_word_t data;
		led_word_t led;
	} disp_t;

	typedef enum logic [2:0] {tx_idle, tx_start, tx_data, tx_stop, tx_done} tx_state_t;
	typedef enum logic [2:0] {rx_idle, rx_start, rx_data, rx_stop, rx_done} rx_state_t;
	typedef enum logic [1:0] {disp_clear, disp_shift, disp_gap} disp_state_t;

endpackage

/* design/input_conditioner.sv */
`timescale 1ns/1ps
`include "board_consts.svh"

module input_conditioner (
	input  logic               clk_cpu,
	input  logic               rst_i,
	input  board_pkg::switch_t switch_i,
	input  board_pkg::btn_t    btn_i,
	output board_pkg::ui_in_t  ui_o,
	output logic               sys_rst_o
);
	import board_pkg::*;

	localparam int NUM_IN = $bits(ui_in_t);
	localparam int JW = $clog2(`JITTER_MAX + 1);
	localparam int RW = $clog2(`RST_STRETCH + 1);
	localparam logic [JW-1:0] JIT_LAST = JW'(`JITTER_MAX - 1);
	localparam logic [RW-1:0] RST_LOAD = RW'(`RST_STRETCH);

	ui_in_t raw;
	ui_in_t clean;
	logic [JW-1:0] stab_cnt [NUM_IN];
	logic [RW-1:0] rst_cnt;
	logic sys_rst;

	// raw inputs in the same layout as the conditioned copy
	assign raw = '{sw: switch_i, btn: btn_i};

	// one stability counter per input bit
	// counts samples that differ from the conditioned level
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			clean <= '0;
			for (int i = 0; i < NUM_IN; i++) begin
				stab_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_IN; i++) begin
				if (raw[i] == clean[i]) begin
					// bounce back, start over
					stab_cnt[i] <= '0;
				end else if (stab_cnt[i] == JIT_LAST) begin
					// new level held long enough
					clean[i] <= raw[i];
					stab_cnt[i] <= '0;
				end else begin
					stab_cnt[i] <= stab_cnt[i] + 1'b1;
				end
			end
		end
	end

	// reset stretch, reloads while rst_i is high
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			rst_cnt <= RST_LOAD;
			sys_rst <= 1'b1;
		end else begin
			if (rst_cnt != '0) begin
				rst_cnt <= rst_cnt - 1'b1;
			end
			sys_rst <= (rst_cnt != '0);
		end
	end

	assign ui_o = clean;
	assign sys_rst_o = sys_rst;

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ps
`include "board_consts.svh"

module uart_tx (
	input  logic            clk_cpu,
	input  logic            rst_i,
	input  logic            tx_req_i,
	input  board_pkg::byte_t tx_byte_i,
	output logic            tx_ack_o,
	output logic            uart_tx_o
);
	import board_pkg::*;

	localparam int BW = $clog2(`UART_DIV);
	localparam logic [BW-1:0] BIT_END = BW'(`UART_DIV - 1);

	tx_state_t state;
	logic [BW-1:0] baud_cnt;
	logic [2:0] bit_idx;
	byte_t shreg;
	logic line_q;
	logic ack_q;
	logic bit_done;

	// last cycle of the current bit
	assign bit_done = (baud_cnt == BIT_END);

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			state <= tx_idle;
			baud_cnt <= '0;
			bit_idx <= '0;
			line_q <= 1'b1;
			ack_q <= 1'b0;
		end else begin
			case (state)
				tx_idle: begin
					baud_cnt <= '0;
					if (tx_req_i) begin
						// start bit goes out on the next cycle
						line_q <= 1'b0;
						ack_q <= 1'b1;
						state <= tx_start;
					end
				end
				tx_start: begin
					if (bit_done) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						line_q <= shreg[0];
						state <= tx_data;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				tx_data: begin
					if (bit_done) begin
						baud_cnt <= '0;
						if (bit_idx == 3'd7) begin
							// stop bit
							line_q <= 1'b1;
							state <= tx_stop;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							line_q <= shreg[1];
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				tx_stop: begin
					if (bit_done) begin
						baud_cnt <= '0;
						state <= tx_done;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				tx_done: begin
					// ack falls only after the stop bit and the dropped request
					if (!tx_req_i) begin
						ack_q <= 1'b0;
						state <= tx_idle;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

	// data shifter, lsb first
	always_ff @(posedge clk_cpu) begin
		if (state == tx_idle && tx_req_i) begin
			shreg <= tx_byte_i;
		end else if (state == tx_data && bit_done) begin
			shreg <= shreg >> 1;
		end
	end

	assign tx_ack_o = ack_q;
	assign uart_tx_o = line_q;

endmodule

/* design/uart_rx.sv */
`timescale 1ns/1ps
`include "board_consts.svh"

module uart_rx (
	input  logic             clk_cpu,
	input  logic             rst_i,
	input  logic             uart_rx_i,
	output logic             rx_req_o,
	output board_pkg::byte_t rx_byte_o,
	input  logic             rx_ack_i,
	output logic             frame_err_o
);
	import board_pkg::*;

	localparam int BW = $clog2(`UART_DIV);
	localparam logic [BW-1:0] BIT_END = BW'(`UART_DIV - 1);
	localparam logic [BW-1:0] HALF_END = BW'(`UART_DIV / 2 - 1);

	rx_state_t state;
	logic [1:0] sync_q;
	logic rx_s;
	logic [BW-1:0] baud_cnt;
	logic [2:0] bit_idx;
	byte_t shreg;
	byte_t byte_q;
	logic req_q;
	logic ferr_q;
	logic bit_done;
	logic stop_good;
	logic stop_bad;

	// two-flop synchronizer, line idles high
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {sync_q[0], uart_rx_i};
		end
	end

	assign rx_s = sync_q[1];
	assign bit_done = (baud_cnt == BIT_END);
	// middle of the stop bit
	assign stop_good = (state == rx_stop) && bit_done && rx_s;
	assign stop_bad = (state == rx_stop) && bit_done && !rx_s;

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			state <= rx_idle;
			baud_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				rx_idle: begin
					baud_cnt <= '0;
					if (!rx_s) begin
						state <= rx_start;
					end
				end
				rx_start: begin
					// half-bit wait to land in the middle of the start bit
					if (baud_cnt == HALF_END) begin
						baud_cnt <= '0;
						bit_idx <= '0;
						// a short glitch is not a start bit
						state <= rx_s ? rx_idle : rx_data;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (bit_done) begin
						baud_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= rx_stop;
						end
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_stop: begin
					if (bit_done) begin
						baud_cnt <= '0;
						state <= rx_done;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				rx_done: begin
					// wait for an idle line after a low stop bit
					if (rx_s) begin
						state <= rx_idle;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	// sample shifter, lsb arrives first
	always_ff @(posedge clk_cpu) begin
		if (state == rx_data && bit_done) begin
			shreg <= {rx_s, shreg[7:1]};
		end
		// overrun: a byte finishing during an open request overwrites this one
		if (stop_good) begin
			byte_q <= shreg;
		end
	end

	// request side of the four-phase link
	// while ack is still high a new byte gets no request of its own
	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			req_q <= 1'b0;
			ferr_q <= 1'b0;
		end else begin
			ferr_q <= stop_bad;
			if (stop_good && !rx_ack_i) begin
				req_q <= 1'b1;
			end else if (rx_ack_i) begin
				req_q <= 1'b0;
			end
		end
	end

	assign rx_req_o = req_q;
	assign rx_byte_o = byte_q;
	assign frame_err_o = ferr_q;

endmodule

/* design/uart_test_ctrl.sv */
`timescale 1ns/1ps

module uart_test_ctrl (
	input  logic              clk_cpu,
	input  logic              rst_i,
	input  board_pkg::ui_in_t ui_i,
	output logic              tx_req_o,
	output board_pkg::byte_t  tx_byte_o,
	input  logic              tx_ack_i,
	input  logic              rx_req_i,
	input  board_pkg::byte_t  rx_byte_i,
	output logic              rx_ack_o,
	input  logic              frame_err_i,
	output board_pkg::disp_t  disp_o
);
	import board_pkg::*;

	byte_t tx_cnt;
	byte_t rx_cnt;
	byte_t last_tx;
	byte_t last_rx;
	logic sw14_q;
	logic ack_q;
	logic ferr_sticky;
	logic busy;
	logic send_cmd;
	logic tx_done;
	logic rx_take;

	// transmitter in use from request until ack falls
	assign busy = tx_req_o | tx_ack_i;
	// cs high, we rising
	assign send_cmd = ui_i.sw[15] & ui_i.sw[14] & ~sw14_q;
	// falling edge of ack, frame fully sent
	assign tx_done = ack_q & ~tx_ack_i;
	// new request from the receiver
	assign rx_take = rx_req_i & ~rx_ack_o;

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			sw14_q <= 1'b0;
			ack_q <= 1'b0;
			tx_req_o <= 1'b0;
			rx_ack_o <= 1'b0;
			tx_cnt <= '0;
			rx_cnt <= '0;
			last_tx <= '0;
			last_rx <= '0;
			ferr_sticky <= 1'b0;
		end else begin
			sw14_q <= ui_i.sw[14];
			ack_q <= tx_ack_i;
			// tx link, edge while busy is dropped
			if (send_cmd && !busy) begin
				tx_req_o <= 1'b1;
			end else if (tx_req_o && tx_ack_i) begin
				tx_req_o <= 1'b0;
			end
			if (tx_done) begin
				tx_cnt <= tx_cnt + 1'b1;
				last_tx <= tx_byte_o;
			end
			// rx link, ack simply follows the request
			rx_ack_o <= rx_req_i;
			if (rx_take) begin
				rx_cnt <= rx_cnt + 1'b1;
				last_rx <= rx_byte_i;
			end
			if (frame_err_i) begin
				ferr_sticky <= 1'b1;
			end
		end
	end

	// byte held stable for the whole request
	always_ff @(posedge clk_cpu) begin
		if (send_cmd && !busy) begin
			tx_byte_o <= ui_i.sw[7:0];
		end
	end

	// display words, refreshed every cycle
	always_ff @(posedge clk_cpu) begin
		disp_o.data <= {last_rx, last_tx, rx_cnt, tx_cnt};
		disp_o.led <= {ui_i.sw[7:0], ui_i.btn, ui_i.sw[14], ui_i.sw[15], ferr_sticky, busy};
	end

endmodule

/* design/disp_serializer.sv */
`timescale 1ns/1ps
`include "board_consts.svh"

module disp_serializer (
	input  logic             clk_cpu,
	input  logic             rst_i,
	input  board_pkg::disp_t disp_i,
	output logic             seg_clk_o,
	output logic             seg_clr_n_o,
	output logic             seg_do_o,
	output logic             led_clk_o,
	output logic             led_clr_n_o,
	output logic             led_do_o
);
	import board_pkg::*;

	localparam int DW = $clog2(`DISP_DIV + 1);
	localparam logic [DW-1:0] HALF_END = DW'(`DISP_DIV - 1);
	localparam logic [5:0] SEG_LAST = 6'($bits(disp_word_t) - 1);
	localparam logic [5:0] LED_BITS = 6'($bits(led_word_t));
	localparam logic [5:0] GAP_LAST = 6'd3;

	disp_state_t state;
	logic [DW-1:0] div_cnt;
	logic [5:0] bit_cnt;
	logic sclk_q;
	logic led_clk_q;
	logic clr_n_q;
	disp_word_t seg_sr;
	led_word_t led_sr;
	logic half_done;

	assign half_done = (div_cnt == HALF_END);

	always_ff @(posedge clk_cpu) begin
		if (rst_i) begin
			// gap first, so clr_n starts high
			state <= disp_gap;
			div_cnt <= '0;
			bit_cnt <= '0;
			sclk_q <= 1'b0;
			led_clk_q <= 1'b0;
			clr_n_q <= 1'b1;
		end else begin
			case (state)
				disp_clear: begin
					// one cycle with clr_n low
					clr_n_q <= 1'b1;
					div_cnt <= '0;
					bit_cnt <= '0;
					state <= disp_shift;
				end
				disp_shift: begin
					if (half_done) begin
						div_cnt <= '0;
						if (!sclk_q) begin
							// rising edge, led chain only for its 16 bits
							sclk_q <= 1'b1;
							led_clk_q <= (bit_cnt < LED_BITS);
						end else begin
							sclk_q <= 1'b0;
							led_clk_q <= 1'b0;
							if (bit_cnt == SEG_LAST) begin
								bit_cnt <= '0;
								state <= disp_gap;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				disp_gap: begin
					// bit_cnt reused as gap counter
					if (bit_cnt == GAP_LAST) begin
						bit_cnt <= '0;
						clr_n_q <= 1'b0;
						state <= disp_clear;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= disp_gap;
			endcase
		end
	end

	// frame copy at clear, next bit on the falling serial clock
	always_ff @(posedge clk_cpu) begin
		if (state == disp_clear) begin
			seg_sr <= disp_i.data;
			led_sr <= disp_i.led;
		end else if (state == disp_shift && half_done && sclk_q) begin
			seg_sr <= seg_sr << 1;
			led_sr <= led_sr << 1;
		end
	end

	// both chains share clear and data timing
	assign seg_clk_o = sclk_q;
	assign led_clk_o = led_clk_q;
	assign seg_clr_n_o = clr_n_q;
	assign led_clr_n_o = clr_n_q;
	assign seg_do_o = seg_sr[$bits(disp_word_t)-1];
	assign led_do_o = led_sr[$bits(led_word_t)-1];

endmodule

/* design/test_frame_uart.sv */
`timescale 1ns/1ps

module test_frame_uart (
	input  logic               clk_cpu,
	input  logic               rst_i,
	input  board_pkg::switch_t switch_i,
	input  board_pkg::btn_t    btn_i,
	input  logic               uart_rx_i,
	output logic               uart_tx_o,
	output logic               seg_clk_o,
	output logic               seg_clr_n_o,
	output logic               seg_do_o,
	output logic               led_clk_o,
	output logic               led_clr_n_o,
	output logic               led_do_o
);
	import board_pkg::*;

	// conditioned inputs and stretched reset
	ui_in_t ui;
	logic sys_rst;
	// tx link
	logic tx_req;
	byte_t tx_byte;
	logic tx_ack;
	// rx link
	logic rx_req;
	byte_t rx_byte;
	logic rx_ack;
	logic frame_err;
	// display frame
	disp_t disp;

	input_conditioner input_cond (
		.clk_cpu  (clk_cpu),
		.rst_i    (rst_i),
		.switch_i (switch_i),
		.btn_i    (btn_i),
		.ui_o     (ui),
		.sys_rst_o(sys_rst)
	);

	uart_tx tx (
		.clk_cpu  (clk_cpu),
		.rst_i    (sys_rst),
		.tx_req_i (tx_req),
		.tx_byte_i(tx_byte),
		.tx_ack_o (tx_ack),
		.uart_tx_o(uart_tx_o)
	);

	uart_rx rx (
		.clk_cpu    (clk_cpu),
		.rst_i      (sys_rst),
		.uart_rx_i  (uart_rx_i),
		.rx_req_o   (rx_req),
		.rx_byte_o  (rx_byte),
		.rx_ack_i   (rx_ack),
		.frame_err_o(frame_err)
	);

	uart_test_ctrl ctrl (
		.clk_cpu    (clk_cpu),
		.rst_i      (sys_rst),
		.ui_i       (ui),
		.tx_req_o   (tx_req),
		.tx_byte_o  (tx_byte),
		.tx_ack_i   (tx_ack),
		.rx_req_i   (rx_req),
		.rx_byte_i  (rx_byte),
		.rx_ack_o   (rx_ack),
		.frame_err_i(frame_err),
		.disp_o     (disp)
	);

	disp_serializer disp_ser (
		.clk_cpu    (clk_cpu),
		.rst_i      (sys_rst),
		.disp_i     (disp),
		.seg_clk_o  (seg_clk_o),
		.seg_clr_n_o(seg_clr_n_o),
		.seg_do_o   (seg_do_o),
		.led_clk_o  (led_clk_o),
		.led_clr_n_o(led_clr_n_o),
		.led_do_o   (led_do_o)
	);

endmodule

/* dv/tb_test_frame.sv */
`timescale 1ns/1ps
`include "board_consts.svh"

module tb_test_frame;
	import board_pkg::*;

	localparam int CLK_PERIOD = 10;
	// start bit plus 8 data bits plus stop bit
	localparam int FRAME_CYCLES = 10 * `UART_DIV;
	// clear cycle plus 32 bits of two half periods plus the 4-cycle gap
	localparam int DISP_FRAME_CYCLES = 1 + 64 * `DISP_DIV + 4;
	// one uart frame plus two display frames plus slack per step
	localparam int STEP_CYCLES = FRAME_CYCLES + 2 * DISP_FRAME_CYCLES + 50;
	// about 40 steps over all tests
	localparam int WATCHDOG_NS = 42 * STEP_CYCLES * CLK_PERIOD;

	logic clk_cpu;
	logic rst_i;
	switch_t switch_i;
	btn_t btn_i;
	logic loopback;
	logic rx_drive;
	wire uart_rx_i;
	logic uart_tx_o;
	logic seg_clk_o;
	logic seg_clr_n_o;
	logic seg_do_o;
	logic led_clk_o;
	logic led_clr_n_o;
	logic led_do_o;

	int errors;
	int err_mark;
	int tests_passed;
	int tests_failed;
	integer seed;
	// reference model of the counts and last bytes
	byte_t exp_tx_cnt;
	byte_t exp_rx_cnt;
	byte_t exp_last_tx;
	byte_t exp_last_rx;

	// loopback wire or the line from the driver task
	assign uart_rx_i = loopback ? uart_tx_o : rx_drive;

	test_frame_uart UUT (
		.clk_cpu    (clk_cpu),
		.rst_i      (rst_i),
		.switch_i   (switch_i),
		.btn_i      (btn_i),
		.uart_rx_i  (uart_rx_i),
		.uart_tx_o  (uart_tx_o),
		.seg_clk_o  (seg_clk_o),
		.seg_clr_n_o(seg_clr_n_o),
		.seg_do_o   (seg_do_o),
		.led_clk_o  (led_clk_o),
		.led_clr_n_o(led_clr_n_o),
		.led_do_o   (led_do_o)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	// returns 1 ns after the rising edge where inputs change
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_cpu);
		#1;
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			$display("test %s passed", name);
			tests_passed++;
		end else begin
			$display("test %s failed with %0d errors", name, errors - err_mark);
			tests_failed++;
		end
	endtask

	// next display frame sampled on the rising serial clock
	task automatic read_frame(output disp_word_t data, output led_word_t led);
		int waited;
		int led_pulses;
		waited = 0;
		led_pulses = 0;
		data = '0;
		led = '0;
		// frame opens with one cycle of clr_n low
		@(negedge clk_cpu);
		while (seg_clr_n_o !== 1'b0 && waited < 2 * DISP_FRAME_CYCLES) begin
			@(negedge clk_cpu);
			waited++;
		end
		if (seg_clr_n_o !== 1'b0) begin
			$display("no display frame started within %0d cycles at %0t", waited, $time);
			errors++;
		end else begin
			check_val("led_clr_n_o", 32'(led_clr_n_o), 32'(0));
			for (int i = 0; i < 32; i++) begin
				@(posedge seg_clk_o);
				// both serial clocks settled after the edge
				#1;
				data = {data[30:0], seg_do_o};
				// led chain clocks only with the first 16 bits
				if (led_clk_o === 1'b1) begin
					led_pulses++;
				end
				if (i < 16) begin
					led = {led[14:0], led_do_o};
				end
			end
			check_val("led_clk_o pulses", led_pulses, 16);
		end
	endtask

	task automatic check_display(output led_word_t led);
		disp_word_t data;
		read_frame(data, led);
		check_val("seg data word", data, {exp_last_rx, exp_last_tx, exp_rx_cnt, exp_tx_cnt});
	endtask

	// capture one frame from uart_tx_o with one sample per cycle
	task automatic decode_uart(input byte_t exp_b);
		logic [FRAME_CYCLES-1:0] wave;
		byte_t got;
		int waited;
		int mism;
		int pos;
		logic exp_bit;
		waited = 0;
		mism = 0;
		got = '0;
		@(negedge clk_cpu);
		while (uart_tx_o !== 1'b0 && waited < 8 * `UART_DIV) begin
			@(negedge clk_cpu);
			waited++;
		end
		if (uart_tx_o !== 1'b0) begin
			$display("no start bit on uart_tx_o within %0d cycles at %0t", waited, $time);
			errors++;
		end else begin
			wave[0] = 1'b0;
			for (int i = 1; i < FRAME_CYCLES; i++) begin
				@(negedge clk_cpu);
				wave[i] = uart_tx_o;
			end
			// mid-bit decode
			for (int k = 0; k < 8; k++) begin
				got[k] = wave[(k + 1) * `UART_DIV + `UART_DIV / 2];
			end
			// every sample against a low start bit, lsb first data and a high stop bit
			for (int i = 0; i < FRAME_CYCLES; i++) begin
				pos = i / `UART_DIV;
				if (pos == 0) begin
					exp_bit = 1'b0;
				end else if (pos == 9) begin
					exp_bit = 1'b1;
				end else begin
					exp_bit = exp_b[pos - 1];
				end
				if (wave[i] !== exp_bit) begin
					mism++;
				end
			end
			check_val("uart_tx_o byte", 32'(got), 32'(exp_b));
			check_val("uart_tx_o stop bit", 32'(wave[9 * `UART_DIV + `UART_DIV / 2]), 1);
			check_val("uart_tx_o samples off bit timing", mism, 0);
		end
	endtask

	// cs high and byte on the low switches before we rises
	task automatic send_and_check(input byte_t b);
		switch_i[7:0] = b;
		switch_i[15] = 1'b1;
		switch_i[14] = 1'b0;
		wait_cycles(`JITTER_MAX + 4);
		switch_i[14] = 1'b1;
		decode_uart(b);
		// ack falls shortly after the stop bit
		wait_cycles(4);
		switch_i[14] = 1'b0;
		exp_tx_cnt = exp_tx_cnt + 8'd1;
		exp_last_tx = b;
		if (loopback) begin
			exp_rx_cnt = exp_rx_cnt + 8'd1;
			exp_last_rx = b;
		end
	endtask

	// uart_tx_o must stay high for n cycles
	task automatic watch_idle(input int n);
		int lows;
		lows = 0;
		repeat (n) begin
			@(negedge clk_cpu);
			if (uart_tx_o !== 1'b1) begin
				lows++;
			end
		end
		check_val("uart_tx_o low cycles", lows, 0);
	endtask

	task automatic drive_rx_frame(input byte_t b, input logic stop_bit);
		rx_drive = 1'b0;
		wait_cycles(`UART_DIV);
		for (int k = 0; k < 8; k++) begin
			rx_drive = b[k];
			wait_cycles(`UART_DIV);
		end
		rx_drive = stop_bit;
		wait_cycles(`UART_DIV);
		rx_drive = 1'b1;
	endtask

	task automatic test_reset_state();
		disp_word_t data;
		led_word_t led;
		led_word_t exp_led;
		err_mark = errors;
		@(negedge clk_cpu);
		check_val("uart_tx_o", 32'(uart_tx_o), 1);
		read_frame(data, led);
		check_val("seg data word", data, 0);
		// switches 7..0 and buttons above we and cs with error and busy clear
		exp_led = {switch_i[7:0], btn_i, switch_i[14], switch_i[15], 2'b00};
		check_val("led word", 32'(led), 32'(exp_led));
		end_test("reset_state");
	endtask

	task automatic test_single_send();
		led_word_t led;
		err_mark = errors;
		wait_cycles(1);
		send_and_check(8'hA6);
		wait_cycles(2);
		check_display(led);
		check_val("led busy bit", 32'(led[0]), 0);
		end_test("single_send");
	endtask

	task automatic test_loopback_burst();
		led_word_t led;
		byte_t b;
		err_mark = errors;
		wait_cycles(1);
		loopback = 1'b1;
		for (int n = 0; n < 4; n++) begin
			b = 8'($random(seed));
			send_and_check(b);
		end
		wait_cycles(2);
		check_display(led);
		loopback = 1'b0;
		end_test("loopback_burst");
	endtask

	task automatic test_no_send();
		led_word_t led;
		err_mark = errors;
		wait_cycles(1);
		switch_i[15] = 1'b0;
		switch_i[14] = 1'b0;
		wait_cycles(`JITTER_MAX + 4);
		// we rising with cs low
		switch_i[14] = 1'b1;
		watch_idle(4 * `UART_DIV);
		wait_cycles(1);
		switch_i[14] = 1'b0;
		wait_cycles(`JITTER_MAX + 4);
		switch_i[15] = 1'b1;
		wait_cycles(`JITTER_MAX + 4);
		// we pulse too short for the debounce
		switch_i[14] = 1'b1;
		wait_cycles(`JITTER_MAX - 1);
		switch_i[14] = 1'b0;
		watch_idle(4 * `UART_DIV);
		wait_cycles(2);
		check_display(led);
		end_test("no_send");
	endtask

	task automatic test_frame_error();
		led_word_t led;
		err_mark = errors;
		wait_cycles(1);
		// the receiver drops a byte with a low stop bit
		drive_rx_frame(8'h3C, 1'b0);
		wait_cycles(2);
		check_display(led);
		check_val("led frame error bit", 32'(led[1]), 1);
		end_test("frame_error");
	endtask

	initial begin
		rst_i = 1'b1;
		switch_i = 16'h805A;
		btn_i = 4'b1001;
		loopback = 1'b0;
		rx_drive = 1'b1;
		errors = 0;
		err_mark = 0;
		tests_passed = 0;
		tests_failed = 0;
		seed = 48970;
		exp_tx_cnt = '0;
		exp_rx_cnt = '0;
		exp_last_tx = '0;
		exp_last_rx = '0;
		repeat (8) @(posedge clk_cpu);
		#1;
		rst_i = 1'b0;
		test_reset_state();
		test_single_send();
		test_loopback_burst();
		test_no_send();
		test_frame_error();
		$display("tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+design
design/board_pkg.sv
design/input_conditioner.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_test_ctrl.sv
design/disp_serializer.sv
design/test_frame_uart.sv
dv/tb_test_frame.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# the run passes only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f tb.f --top-module tb_test_frame \
	-Mdir build/obj_dir -o sim_tb || { echo "build failed"; exit 1; }

sim_out="$(./build/obj_dir/sim_tb 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST OK" && exit 0 || exit 1
